//--- logic/seqTimingPkg.sv
/*
 * Timing types for the reset sequencer
 * Enabled-cycle counter width and the phase encoding
 */
package seqTimingPkg;

    // Covers the largest default sequence total
    localparam int cycleCountWidth = 24;

    typedef logic [cycleCountWidth-1:0] cycleCount_t;

    // Order follows the power-up sequence
    typedef enum logic [2:0] {
        idle,
        resetHold,
        resetBarrier,
        operHold,
        enableBarrier,
        initHold,
        done
    } seqPhase_t;

endpackage

//--- logic/domainPkg.sv
/*
 * Clock-domain handshake types
 * Per-domain mask and four-phase barrier states
 */
package domainPkg;

    // Most domains one barrier can serve
    localparam int maxDomains = 16;

    typedef logic [maxDomains-1:0] domainMask_t;

    // Progress of one req/ack round
    typedef enum logic [1:0] {
        open,
        raise,
        lower
    } barrierState_t;

endpackage

//--- logic/resetCapture.sv
/*
 * Start capture for the reset sequencer
 * Reset release, clock-enable rising edge and synchronous restart
 */
module resetCapture (
    input  logic clk,
    input  logic async_rst_in,
    input  logic clkEn,
    input  logic syncRstReq,
    output logic seqStart,
    output logic restart
);

    logic [7:0] capture;
    logic       clkEnPrev;
    logic       restartReg;
    logic       fillDone;
    logic       clkEnRise;
    logic       restartEnd;

    // Fills one stage per enabled cycle after release
    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            capture <= '0;
        end else if (clkEn) begin
            capture <= {capture[6:0], 1'b1};
        end
    end

    // Seventh stage set, last stage about to fill
    assign fillDone = clkEn && capture[6] && !capture[7];

    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            clkEnPrev <= 1'b0;
        end else begin
            clkEnPrev <= clkEn;
        end
    end

    // Only after the release pulse has gone out
    assign clkEnRise = clkEn && !clkEnPrev && capture[7];

    // Restart request sampled on enabled cycles
    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            restartReg <= 1'b0;
        end else if (clkEn) begin
            restartReg <= syncRstReq;
        end
    end

    // Request seen low again on an enabled cycle
    assign restartEnd = clkEn && restartReg && !syncRstReq;

    assign restart  = restartReg;
    assign seqStart = fillDone || clkEnRise || restartEnd;

endmodule

//--- logic/phaseSequencer.sv
/*
 * Phase state machine and enabled-cycle counter
 * Drives the reset, clock-enable and init outputs of the sequence
 */
module phaseSequencer #(
    parameter int resetWaitCycles       = 625000,
    parameter int operationalWaitCycles = 25000,
    parameter int initializeWaitCycles  = 1024
) (
    input  logic clk,
    input  logic async_rst_in,
    input  logic clkEn,
    input  logic seqStart,
    input  logic restart,
    input  logic barrierDone,
    output logic barrierReq,
    output logic asyncRstOut,
    output logic syncRstOut,
    output logic clkEnOut,
    output logic initOut
);
    import seqTimingPkg::*;

    // Last count value of each hold
    localparam cycleCount_t resetLast = cycleCount_t'(resetWaitCycles - 1);
    localparam cycleCount_t operLast  = cycleCount_t'(operationalWaitCycles - 1);
    localparam cycleCount_t initLast  = cycleCount_t'(initializeWaitCycles - 1);

    // Domain async reset covers the first quarter of the operational hold
    localparam int          asyncWindow = operationalWaitCycles / 4;
    localparam cycleCount_t asyncLast   = cycleCount_t'(asyncWindow - 1);

    seqPhase_t   phase;
    seqPhase_t   nextPhase;
    cycleCount_t count;
    logic        startSeq;
    logic        clearSeq;
    logic        counting;
    logic        resetHit;
    logic        operHit;
    logic        initHit;
    logic        windowEnd;

    // A start on the last restart cycle wins over the restart
    assign startSeq = seqStart && (phase == idle);
    assign clearSeq = restart && !startSeq;

    assign counting = clkEn && ((phase == resetHold) || (phase == operHold) ||
                                (phase == initHold));

    assign resetHit  = clkEn && (phase == resetHold) && (count == resetLast);
    assign operHit   = clkEn && (phase == operHold) && (count == operLast);
    assign initHit   = clkEn && (phase == initHold) && (count == initLast);
    assign windowEnd = clkEn && (phase == operHold) && (count == asyncLast);

    always_comb begin
        nextPhase = phase;
        case (phase)
            idle: begin
                if (seqStart) begin
                    nextPhase = resetHold;
                end
            end
            resetHold: begin
                if (resetHit) begin
                    nextPhase = resetBarrier;
                end
            end
            resetBarrier: begin
                if (barrierDone) begin
                    nextPhase = operHold;
                end
            end
            operHold: begin
                if (operHit) begin
                    nextPhase = enableBarrier;
                end
            end
            enableBarrier: begin
                if (barrierDone) begin
                    nextPhase = initHold;
                end
            end
            initHold: begin
                if (initHit) begin
                    nextPhase = done;
                end
            end
            default: begin
                nextPhase = phase;
            end
        endcase
        if (clearSeq) begin
            nextPhase = idle;
        end
    end

    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            phase <= idle;
        end else begin
            phase <= nextPhase;
        end
    end

    // Holds through the barrier phases, restarts on every phase change
    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            count <= '0;
        end else if (startSeq || clearSeq || (nextPhase != phase)) begin
            count <= '0;
        end else if (counting) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            asyncRstOut <= 1'b0;
            syncRstOut  <= 1'b0;
            clkEnOut    <= 1'b0;
            initOut     <= 1'b0;
        end else if (clearSeq) begin
            asyncRstOut <= 1'b0;
            syncRstOut  <= 1'b0;
            clkEnOut    <= 1'b0;
            initOut     <= 1'b0;
        end else begin
            syncRstOut <= resetHit;
            clkEnOut   <= operHit;
            initOut    <= initHit;
            // Window opens as the first barrier completes
            if ((phase == resetBarrier) && barrierDone && (asyncWindow > 0)) begin
                asyncRstOut <= 1'b1;
            end else if (windowEnd) begin
                asyncRstOut <= 1'b0;
            end
        end
    end

    // Rises together with the syncRstOut and clkEnOut pulses
    assign barrierReq = (phase == resetBarrier) || (phase == enableBarrier);

endmodule

//--- logic/domainBarrier.sv
/*
 * Four-phase req/ack barrier across all clock domains
 */
module domainBarrier #(
    parameter int domainCount = 3
) (
    input  logic                   clk,
    input  logic                   async_rst_in,
    input  logic                   barrierReq,
    input  domainPkg::domainMask_t syncAck,
    output domainPkg::domainMask_t syncReq,
    output logic                   barrierDone
);
    import domainPkg::*;

    // Populated domains only
    localparam domainMask_t activeMask = domainMask_t'((32'd1 << domainCount) - 32'd1);

    barrierState_t state;
    domainMask_t   ackSeen;
    logic          allHigh;
    logic          allLow;

    assign ackSeen = syncAck & activeMask;
    assign allHigh = (ackSeen == activeMask);
    assign allLow  = (ackSeen == '0);

    // Aborted rounds finish quietly
    assign barrierDone = (state == lower) && allLow && barrierReq;

    always_ff @(posedge clk or posedge async_rst_in) begin
        if (async_rst_in) begin
            state   <= open;
            syncReq <= '0;
        end else begin
            case (state)
                open: begin
                    if (barrierReq) begin
                        state   <= raise;
                        syncReq <= activeMask;
                    end
                end
                raise: begin
                    // Withdrawn request also waits for the acks to drop
                    if (allHigh || !barrierReq) begin
                        state   <= lower;
                        syncReq <= '0;
                    end
                end
                lower: begin
                    if (allLow) begin
                        state <= open;
                    end
                end
                default: begin
                    state   <= open;
                    syncReq <= '0;
                end
            endcase
        end
    end

endmodule

//--- logic/resetSeqTop.sv
/*
 * Reset sequencer top level
 * Start capture, phase sequencer and domain barrier
 */
module resetSeqTop #(
    parameter int resetWaitCycles       = 625000,
    parameter int operationalWaitCycles = 25000,
    parameter int initializeWaitCycles  = 1024,
    parameter int domainCount           = 3
) (
    input  logic                   clk,
    input  logic                   async_rst_in,
    input  logic                   clkEn,
    input  logic                   syncRstReq,
    input  logic [domainCount-1:0] syncAck,
    output logic                   asyncRstOut,
    output logic                   syncRstOut,
    output logic                   clkEnOut,
    output logic                   initOut,
    output logic [domainCount-1:0] syncReq
);
    import domainPkg::*;

    logic        seqStart;
    logic        restart;
    logic        barrierReq;
    logic        barrierDone;
    domainMask_t ackMask;
    domainMask_t reqMask;

    // Upper mask bits stay zero
    assign ackMask = domainMask_t'(syncAck);
    assign syncReq = reqMask[domainCount-1:0];

    resetCapture uCapture (
        .clk         (clk),
        .async_rst_in(async_rst_in),
        .clkEn       (clkEn),
        .syncRstReq  (syncRstReq),
        .seqStart    (seqStart),
        .restart     (restart)
    );

    phaseSequencer #(
        .resetWaitCycles      (resetWaitCycles),
        .operationalWaitCycles(operationalWaitCycles),
        .initializeWaitCycles (initializeWaitCycles)
    ) uSequencer (
        .clk         (clk),
        .async_rst_in(async_rst_in),
        .clkEn       (clkEn),
        .seqStart    (seqStart),
        .restart     (restart),
        .barrierDone (barrierDone),
        .barrierReq  (barrierReq),
        .asyncRstOut (asyncRstOut),
        .syncRstOut  (syncRstOut),
        .clkEnOut    (clkEnOut),
        .initOut     (initOut)
    );

    domainBarrier #(
        .domainCount(domainCount)
    ) uBarrier (
        .clk         (clk),
        .async_rst_in(async_rst_in),
        .barrierReq  (barrierReq),
        .syncAck     (ackMask),
        .syncReq     (reqMask),
        .barrierDone (barrierDone)
    );

endmodule

//--- sim/clockGen.sv
/*
 * Testbench clock and power-on reset
 */
module clockGen #(
    parameter int halfPeriod  = 50,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic porRst
);

    initial begin
        clk = 1'b0;
    end

    always #halfPeriod clk = ~clk;

    // Released on a rising edge, like every other driven input
    initial begin
        porRst <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        porRst <= 1'b0;
    end

endmodule

//--- sim/resetSeqTb.sv
/*
 * Directed tests for the reset sequencer
 * Domain ack model, LFSR, watchdog and reporting
 */
module resetSeqTb;
    import domainPkg::*;

    localparam int resetWait   = 40;
    localparam int operWait    = 24;
    localparam int initWait    = 16;
    localparam int domainCount = 3;
    localparam int startDelay  = 8;
    localparam int period      = 100;
    localparam domainMask_t fullMask = domainMask_t'((1 << domainCount) - 1);
    localparam logic [domainCount-1:0] allReq = fullMask[domainCount-1:0];
    // Start delay, three holds and two barriers of up to two ack rounds
    localparam int seqCycles = startDelay + resetWait + operWait + initWait + 4 * 6;
    localparam longint watchdogTime = 64'(6 * seqCycles * 4 * period);

    logic clk;
    logic porRst;
    logic tbRst = 1'b0;
    logic async_rst_in;
    logic clkEn = 1'b1;
    logic syncRstReq = 1'b0;
    logic [domainCount-1:0] syncAck = '0;
    logic [domainCount-1:0] holdAck = '0;
    logic asyncRstOut;
    logic syncRstOut;
    logic clkEnOut;
    logic initOut;
    logic [domainCount-1:0] syncReq;
    logic [31:0] lfsr = 32'h9183baa0;
    logic randomAcks = 1'b0;
    int clkEnMode = 0;
    int ackWait [domainCount] = '{default: 2};
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;

    assign async_rst_in = porRst | tbRst;

    clockGen clockSource (.clk(clk), .porRst(porRst));

    resetSeqTop #(
        .resetWaitCycles      (resetWait),
        .operationalWaitCycles(operWait),
        .initializeWaitCycles (initWait),
        .domainCount          (domainCount)
    ) DUT (
        .clk         (clk),
        .async_rst_in(async_rst_in),
        .clkEn       (clkEn),
        .syncRstReq  (syncRstReq),
        .syncAck     (syncAck),
        .asyncRstOut (asyncRstOut),
        .syncRstOut  (syncRstOut),
        .clkEnOut    (clkEnOut),
        .initOut     (initOut),
        .syncReq     (syncReq)
    );

    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = nextLfsr(lfsr);
            bits = {bits[6:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic int pickDelay();
        if (randomAcks) begin
            return int'(takeBits(2));
        end
        return 2;
    endfunction

    // 0 steady high, 1 random three quarters duty, 2 toggling
    always @(posedge clk) begin
        case (clkEnMode)
            1: clkEn <= (takeBits(2) != 8'd0);
            2: clkEn <= !clkEn;
            default: clkEn <= 1'b1;
        endcase
    end

    // Each domain follows its request after a delay
    always @(posedge clk) begin
        for (int i = 0; i < domainCount; i++) begin
            if (holdAck[i]) begin
                syncAck[i] <= 1'b0;
            end else if (syncAck[i] != syncReq[i]) begin
                if (ackWait[i] == 0) begin
                    syncAck[i] <= syncReq[i];
                    ackWait[i] <= pickDelay();
                end else begin
                    ackWait[i] <= ackWait[i] - 1;
                end
            end
        end
    end

    initial begin
        #(watchdogTime);
        $display("error: watchdog expired in sequencer phase %0d", DUT.uSequencer.phase);
        $display("Simulation failed");
        $finish;
    end

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportFailure(input string name, input string text);
        $display("error %s: %s", name, text);
        errorCount++;
    endtask

    task automatic checkQuiet(input string name);
        if (asyncRstOut || syncRstOut || clkEnOut || initOut || (syncReq != '0)) begin
            reportFailure(name, "an output is active where all should be low");
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed", name);
        end
    endtask

    // Ends on the negedge of the first cycle after release
    task automatic pulseReset(input string name, input int cycles);
        @(posedge clk);
        tbRst <= 1'b1;
        @(negedge clk);
        checkQuiet(name);
        repeat (cycles) @(posedge clk);
        tbRst <= 1'b0;
        @(negedge clk);
    endtask

    task automatic waitForWindow();
        while (!asyncRstOut) begin
            @(negedge clk);
        end
    endtask

    // Called at the negedge of the first cycle after the start reference
    task automatic checkSequence(input string name, input int firstExpect, input int stall);
        int stage;
        int enabledCount;
        int windowCount;
        int stallCount;
        logic sawReq;
        logic sawHigh;
        logic [2:0] prevPulse;
        logic [2:0] curPulse;
        stage = 0;
        enabledCount = 0;
        windowCount = 0;
        stallCount = 0;
        sawReq = 1'b0;
        sawHigh = 1'b0;
        prevPulse = '0;
        while (stage < 5) begin
            curPulse = {syncRstOut, clkEnOut, initOut};
            if ((curPulse & prevPulse) != 3'b0) begin
                reportFailure(name, "a pulse lasted longer than one cycle");
            end
            prevPulse = curPulse;
            if ((syncRstOut && stage > 1) || (clkEnOut && stage != 2) ||
                (initOut && stage != 4) || (asyncRstOut && stage != 2)) begin
                reportFailure(name, "an output pulse came out of order");
            end
            if ((syncReq != '0) && (stage == 0 || stage == 2 || stage == 4)) begin
                reportFailure(name, "syncReq raised outside a barrier");
            end
            case (stage)
                0: begin
                    if (syncRstOut) begin
                        checkValue({name, " reset hold"}, firstExpect, enabledCount);
                        stage = 1;
                    end else if (clkEn) begin
                        enabledCount++;
                    end
                end
                1, 3: begin
                    if (syncReq == allReq) begin
                        sawReq = 1'b1;
                    end
                    if (sawReq && !sawHigh) begin
                        if (syncReq != allReq) begin
                            reportFailure(name, "syncReq dropped before all acks arrived");
                        end
                        stallCount++;
                        if (stallCount == stall) begin
                            holdAck = '0;
                        end
                    end
                    if (sawReq && (syncAck == allReq)) begin
                        sawHigh = 1'b1;
                    end else if (sawHigh && (syncAck == '0)) begin
                        stage++;
                        enabledCount = 0;
                        windowCount = 0;
                        sawReq = 1'b0;
                        sawHigh = 1'b0;
                    end
                end
                2: begin
                    if (clkEnOut) begin
                        checkValue({name, " operational hold"}, operWait, enabledCount);
                        checkValue({name, " async window"}, operWait / 4, windowCount);
                        stage = 3;
                    end else if (clkEn) begin
                        enabledCount++;
                        if (asyncRstOut) begin
                            windowCount++;
                        end
                    end
                end
                default: begin
                    if (initOut) begin
                        checkValue({name, " init hold"}, initWait, enabledCount);
                        stage = 5;
                    end else if (clkEn) begin
                        enabledCount++;
                    end
                end
            endcase
            if (stage < 5) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic powerUpOrder();
        int errorsBefore;
        errorsBefore = errorCount;
        @(negedge clk);
        while (async_rst_in) begin
            checkQuiet("powerUp");
            @(negedge clk);
        end
        checkSequence("powerUp", startDelay + resetWait, 0);
        finishTest("powerUp", errorsBefore);
    endtask

    task automatic gatedLengths();
        int errorsBefore;
        errorsBefore = errorCount;
        clkEnMode = 1;
        randomAcks = 1'b1;
        pulseReset("gated", 3);
        // Start pulse takes the eighth enabled cycle after release
        checkSequence("gated", startDelay + resetWait, 0);
        finishTest("gated", errorsBefore);
    endtask

    task automatic barrierStall();
        int errorsBefore;
        errorsBefore = errorCount;
        clkEnMode = 0;
        randomAcks = 1'b0;
        holdAck = 3'b010;
        pulseReset("stall", 3);
        checkSequence("stall", startDelay + resetWait, 30);
        finishTest("stall", errorsBefore);
    endtask

    task automatic syncRestart();
        int errorsBefore;
        errorsBefore = errorCount;
        clkEnMode = 1;
        randomAcks = 1'b1;
        pulseReset("restart", 3);
        waitForWindow();
        repeat (2) @(negedge clk);
        clkEnMode = 0;
        @(posedge clk);
        syncRstReq <= 1'b1;
        // Async window still open here unless the restart cleared it
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkValue("restart asyncRstOut", 0, int'(asyncRstOut));
        checkValue("restart syncReq", 0, int'(syncReq));
        @(posedge clk);
        @(negedge clk);
        clkEnMode = 1;
        @(posedge clk);
        syncRstReq <= 1'b0;
        @(negedge clk);
        checkSequence("restart", 1 + resetWait, 0);
        finishTest("restart", errorsBefore);
    endtask

    task automatic asyncRestart();
        int errorsBefore;
        errorsBefore = errorCount;
        clkEnMode = 0;
        randomAcks = 1'b0;
        pulseReset("asyncReset", 3);
        waitForWindow();
        repeat (2) @(negedge clk);
        pulseReset("asyncReset", 3);
        checkSequence("asyncReset", startDelay + resetWait, 0);
        finishTest("asyncReset", errorsBefore);
    endtask

    task automatic quietAfterDone();
        int errorsBefore;
        errorsBefore = errorCount;
        clkEnMode = 2;
        repeat (100) begin
            @(negedge clk);
            checkQuiet("completion");
        end
        finishTest("completion", errorsBefore);
    endtask

    initial begin
        powerUpOrder();
        gatedLengths();
        barrierStall();
        syncRestart();
        asyncRestart();
        quietAfterDone();
        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/seqTimingPkg.sv
logic/domainPkg.sv
logic/resetCapture.sv
logic/phaseSequencer.sv
logic/domainBarrier.sv
logic/resetSeqTop.sv
sim/clockGen.sv
sim/resetSeqTb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the reset sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -f filelist.f --top-module resetSeqTb \
    -Mdir obj_dir -o resetSeqSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/resetSeqSim > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$logFile"; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$logFile"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
